// ==== hdl/axi_bus_pkg.sv ====
package axi_bus_pkg;

	////////////////////////////////////////////////////////////
	// Channel widths
	////////////////////////////////////////////////////////////
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = 4;
	localparam int AXI_ID_W   = 6;

	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;
	typedef logic [AXI_STRB_W-1:0] axi_strb_t;
	typedef logic [AXI_ID_W-1:0]   axi_id_t;
	typedef logic [1:0]            axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	////////////////////////////////////////////////////////////
	// Channel payloads
	////////////////////////////////////////////////////////////
	typedef struct packed {
		axi_id_t   id;
		axi_addr_t addr;
	} axi_aw_t;

	typedef struct packed {
		axi_data_t data;
		axi_strb_t strb;
	} axi_w_t;

	typedef struct packed {
		axi_id_t   id;
		axi_resp_t resp;
	} axi_b_t;

	typedef struct packed {
		axi_id_t   id;
		axi_addr_t addr;
	} axi_ar_t;

	typedef struct packed {
		axi_id_t   id;
		axi_data_t data;
		axi_resp_t resp;
		logic      last;
	} axi_r_t;

	// Phases of one single-beat transaction in a channel engine
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCEPT,
		ST_MEM,
		ST_RESP
	} engine_state_t;

endpackage

// ==== hdl/sram_pkg.sv ====
package sram_pkg;

	import axi_bus_pkg::*;

	////////////////////////////////////////////////////////////
	// RAM geometry
	////////////////////////////////////////////////////////////
	localparam int MEM_WORDS  = 256;
	localparam int MEM_IDX_W  = 8;
	// Byte lanes inside one word
	localparam int BYTE_OFS_W = 2;

	typedef logic [MEM_IDX_W-1:0] mem_idx_t;

	////////////////////////////////////////////////////////////
	// Port requests
	////////////////////////////////////////////////////////////
	typedef struct packed {
		mem_idx_t idx;
	} ram_rd_req_t;

	typedef struct packed {
		mem_idx_t  idx;
		axi_data_t data;
		axi_strb_t mask;
	} ram_wr_req_t;

endpackage

// ==== hdl/dual_port_sram.sv ====
module dual_port_sram
	import axi_bus_pkg::*;
	import sram_pkg::*;
(
	input  logic        ACLK,
	input  logic        ARESETn,

	// Read-only port A
	input  logic        rd_req,
	input  ram_rd_req_t rd,
	output logic        rd_accept,
	output logic        rd_done,
	output axi_data_t   rd_data,

	// Masked write-only port B
	input  logic        wr_req,
	input  ram_wr_req_t wr,
	output logic        wr_accept,
	output logic        wr_done
);

	axi_data_t mem [MEM_WORDS];

	// Both ports take a request in the cycle it appears
	assign rd_accept = rd_req;
	assign wr_accept = wr_req;

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	// Read-first so a same-word write lands after the old word is sampled
	always_ff @(posedge ACLK) begin
		if (rd_req)
			rd_data <= mem[rd.idx];
	end

	always_ff @(posedge ACLK) begin
		if (wr_req) begin
			for (int i = 0; i < AXI_STRB_W; i++) begin
				if (wr.mask[i])
					mem[wr.idx][8*i +: 8] <= wr.data[8*i +: 8];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Completion strobes
	////////////////////////////////////////////////////////////
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			rd_done <= 1'b0;
			wr_done <= 1'b0;
		end else begin
			rd_done <= rd_req;
			wr_done <= wr_req;
		end
	end

endmodule

// ==== hdl/axi_write_engine.sv ====
module axi_write_engine
	import axi_bus_pkg::*;
	import sram_pkg::*;
(
	input  logic        ACLK,
	input  logic        ARESETn,

	input  axi_aw_t     aw,
	input  logic        aw_valid,
	output logic        aw_ready,

	input  axi_w_t      w,
	input  logic        w_valid,
	output logic        w_ready,

	output axi_b_t      b,
	output logic        b_valid,
	input  logic        b_ready,

	output ram_wr_req_t wr,
	output logic        wr_req,
	input  logic        wr_accept,
	input  logic        wr_done
);

	engine_state_t state;
	logic          addr_ready;
	logic          wr_xfer;
	logic          in_range;

	// AW and W are always taken on the same edge
	assign aw_ready = addr_ready;
	assign w_ready  = addr_ready;

	assign wr_xfer = aw_valid && aw_ready && w_valid && w_ready;

	// Upper address bits clear means the byte lies inside the RAM
	assign in_range = (aw.addr[AXI_ADDR_W-1:MEM_IDX_W+BYTE_OFS_W] == '0);

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state      <= ST_IDLE;
			addr_ready <= 1'b0;
			wr_req     <= 1'b0;
			b_valid    <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (aw_valid && w_valid) begin
						addr_ready <= 1'b1;
						state      <= ST_ACCEPT;
					end
				end
				ST_ACCEPT: begin
					if (wr_xfer) begin
						addr_ready <= 1'b0;
						if (in_range) begin
							wr_req <= 1'b1;
							state  <= ST_MEM;
						end else begin
							// Dropped write answers straight away
							b_valid <= 1'b1;
							state   <= ST_RESP;
						end
					end
				end
				ST_MEM: begin
					if (wr_accept)
						wr_req <= 1'b0;
					if (wr_done) begin
						b_valid <= 1'b1;
						state   <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (b_ready) begin
						b_valid <= 1'b0;
						state   <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Captured request and held response
	////////////////////////////////////////////////////////////
	always_ff @(posedge ACLK) begin
		if (state == ST_ACCEPT && wr_xfer) begin
			b.id    <= aw.id;
			b.resp  <= in_range ? RESP_OKAY : RESP_SLVERR;
			wr.idx  <= aw.addr[MEM_IDX_W+BYTE_OFS_W-1:BYTE_OFS_W];
			wr.data <= w.data;
			wr.mask <= w.strb;
		end
	end

endmodule

// ==== hdl/axi_read_engine.sv ====
module axi_read_engine
	import axi_bus_pkg::*;
	import sram_pkg::*;
(
	input  logic        ACLK,
	input  logic        ARESETn,

	input  axi_ar_t     ar,
	input  logic        ar_valid,
	output logic        ar_ready,

	output axi_r_t      r,
	output logic        r_valid,
	input  logic        r_ready,

	output ram_rd_req_t rd,
	output logic        rd_req,
	input  logic        rd_accept,
	input  logic        rd_done,
	input  axi_data_t   rd_data
);

	engine_state_t state;
	logic          ar_xfer;
	logic          in_range;

	assign ar_xfer = ar_valid && ar_ready;

	assign in_range = (ar.addr[AXI_ADDR_W-1:MEM_IDX_W+BYTE_OFS_W] == '0);

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state    <= ST_IDLE;
			ar_ready <= 1'b0;
			rd_req   <= 1'b0;
			r_valid  <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (ar_valid) begin
						ar_ready <= 1'b1;
						state    <= ST_ACCEPT;
					end
				end
				ST_ACCEPT: begin
					if (ar_xfer) begin
						ar_ready <= 1'b0;
						if (in_range) begin
							rd_req <= 1'b1;
							state  <= ST_MEM;
						end else begin
							r_valid <= 1'b1;
							state   <= ST_RESP;
						end
					end
				end
				ST_MEM: begin
					if (rd_accept)
						rd_req <= 1'b0;
					if (rd_done) begin
						r_valid <= 1'b1;
						state   <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (r_ready) begin
						r_valid <= 1'b0;
						state   <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// R payload
	////////////////////////////////////////////////////////////
	always_ff @(posedge ACLK) begin
		if (state == ST_ACCEPT && ar_xfer) begin
			r.id   <= ar.id;
			r.resp <= in_range ? RESP_OKAY : RESP_SLVERR;
			r.last <= 1'b1;
			// Zero stays in place for an error response
			r.data <= '0;
			rd.idx <= ar.addr[MEM_IDX_W+BYTE_OFS_W-1:BYTE_OFS_W];
		end else if (state == ST_MEM && rd_done) begin
			r.data <= rd_data;
		end
	end

endmodule

// ==== hdl/axi_dual_port_sram.sv ====
module axi_dual_port_sram
	import axi_bus_pkg::*;
	import sram_pkg::*;
(
	input  logic    ACLK,
	input  logic    ARESETn,

	input  axi_aw_t aw,
	input  logic    aw_valid,
	output logic    aw_ready,

	input  axi_w_t  w,
	input  logic    w_valid,
	output logic    w_ready,

	output axi_b_t  b,
	output logic    b_valid,
	input  logic    b_ready,

	input  axi_ar_t ar,
	input  logic    ar_valid,
	output logic    ar_ready,

	output axi_r_t  r,
	output logic    r_valid,
	input  logic    r_ready
);

	// Read side on port A
	ram_rd_req_t rd;
	logic        rd_req;
	logic        rd_accept;
	logic        rd_done;
	axi_data_t   rd_data;

	// Write side on port B
	ram_wr_req_t wr;
	logic        wr_req;
	logic        wr_accept;
	logic        wr_done;

	axi_write_engine i_write_engine (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.aw        (aw),
		.aw_valid  (aw_valid),
		.aw_ready  (aw_ready),
		.w         (w),
		.w_valid   (w_valid),
		.w_ready   (w_ready),
		.b         (b),
		.b_valid   (b_valid),
		.b_ready   (b_ready),
		.wr        (wr),
		.wr_req    (wr_req),
		.wr_accept (wr_accept),
		.wr_done   (wr_done)
	);

	axi_read_engine i_read_engine (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.ar        (ar),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.r         (r),
		.r_valid   (r_valid),
		.r_ready   (r_ready),
		.rd        (rd),
		.rd_req    (rd_req),
		.rd_accept (rd_accept),
		.rd_done   (rd_done),
		.rd_data   (rd_data)
	);

	dual_port_sram i_sram (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.rd_req    (rd_req),
		.rd        (rd),
		.rd_accept (rd_accept),
		.rd_done   (rd_done),
		.rd_data   (rd_data),
		.wr_req    (wr_req),
		.wr        (wr),
		.wr_accept (wr_accept),
		.wr_done   (wr_done)
	);

endmodule

// ==== test/axi_sram_assert.sv ====
module axi_sram_assert
	import axi_bus_pkg::*;
	import sram_pkg::*;
(
	input logic    ACLK,
	input logic    ARESETn,
	input axi_aw_t aw,
	input logic    aw_valid,
	input logic    aw_ready,
	input axi_w_t  w,
	input logic    w_valid,
	input logic    w_ready,
	input axi_b_t  b,
	input logic    b_valid,
	input logic    b_ready,
	input axi_ar_t ar,
	input logic    ar_valid,
	input logic    ar_ready,
	input axi_r_t  r,
	input logic    r_valid,
	input logic    r_ready
);

	int        fail_count = 0;
	axi_data_t shadow [MEM_WORDS];
	axi_id_t   exp_bid;
	axi_resp_t exp_bresp;
	axi_id_t   exp_rid;
	axi_resp_t exp_rresp;
	axi_data_t exp_rdata;
	logic      seen_valid;
	logic      wr_xfer;
	logic      rd_xfer;
	logic      aw_in;
	logic      ar_in;
	mem_idx_t  aw_idx;
	mem_idx_t  ar_idx;

	assign wr_xfer = aw_valid && aw_ready && w_valid && w_ready;
	assign rd_xfer = ar_valid && ar_ready;
	// A byte is inside the RAM below four bytes per word
	assign aw_in   = aw.addr < MEM_WORDS * 4;
	assign ar_in   = ar.addr < MEM_WORDS * 4;
	assign aw_idx  = mem_idx_t'(aw.addr >> BYTE_OFS_W);
	assign ar_idx  = mem_idx_t'(ar.addr >> BYTE_OFS_W);

	always_ff @(posedge ACLK) begin
		if (!ARESETn)
			seen_valid <= 1'b0;
		else if (aw_valid || w_valid || ar_valid)
			seen_valid <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Shadow memory and expected responses
	////////////////////////////////////////////////////////////
	always_ff @(posedge ACLK) begin
		if (wr_xfer) begin
			exp_bid   <= aw.id;
			exp_bresp <= aw_in ? RESP_OKAY : RESP_SLVERR;
			if (aw_in) begin
				for (int i = 0; i < AXI_STRB_W; i++) begin
					if (w.strb[i])
						shadow[aw_idx][8*i +: 8] <= w.data[8*i +: 8];
				end
			end
		end
		if (rd_xfer) begin
			exp_rid   <= ar.id;
			exp_rresp <= ar_in ? RESP_OKAY : RESP_SLVERR;
			exp_rdata <= ar_in ? shadow[ar_idx] : '0;
		end
	end

	////////////////////////////////////////////////////////////
	// Properties
	////////////////////////////////////////////////////////////
	idle_after_reset: assert property (@(posedge ACLK) disable iff (!ARESETn)
		!seen_valid |-> !(aw_ready || w_ready || ar_ready || b_valid || r_valid))
		else begin
			$error("mismatch at %0t: ready or response valid high before any request", $time);
			fail_count++;
		end

	b_content: assert property (@(posedge ACLK) disable iff (!ARESETn)
		b_valid && b_ready |-> b.id == exp_bid && b.resp == exp_bresp)
		else begin
			$error("mismatch at %0t: B id %0h resp %0h, expected id %0h resp %0h",
				$time, b.id, b.resp, exp_bid, exp_bresp);
			fail_count++;
		end

	r_content: assert property (@(posedge ACLK) disable iff (!ARESETn)
		r_valid && r_ready |-> r.id == exp_rid && r.resp == exp_rresp
			&& r.data == exp_rdata && r.last)
		else begin
			$error("mismatch at %0t: R id %0h data %h resp %0h, expected id %0h data %h resp %0h",
				$time, r.id, r.data, r.resp, exp_rid, exp_rdata, exp_rresp);
			fail_count++;
		end

	// Response held under back-pressure
	b_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
		b_valid && !b_ready |=> b_valid && $stable(b))
		else begin
			$error("mismatch at %0t: B changed before its transfer", $time);
			fail_count++;
		end

	r_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else begin
			$error("mismatch at %0t: R changed before its transfer", $time);
			fail_count++;
		end

	b_latency: assert property (@(posedge ACLK) disable iff (!ARESETn)
		wr_xfer && aw_in |-> ##1 !b_valid ##1 !b_valid ##1 b_valid)
		else begin
			$error("mismatch at %0t: BVALID not three cycles after the write", $time);
			fail_count++;
		end

	r_latency: assert property (@(posedge ACLK) disable iff (!ARESETn)
		rd_xfer && ar_in |-> ##1 !r_valid ##1 !r_valid ##1 r_valid)
		else begin
			$error("mismatch at %0t: RVALID not three cycles after the read", $time);
			fail_count++;
		end

endmodule

bind axi_dual_port_sram axi_sram_assert i_assert (.*);

// ==== test/tb_axi_sram.sv ====
module tb_axi_sram
	import axi_bus_pkg::*;
	import sram_pkg::*;
();

	localparam int WAIT_LIMIT = 50;
	localparam int DRIVE_DLY  = 10;

	logic    ACLK;
	logic    ARESETn;
	axi_aw_t aw;
	logic    aw_valid;
	logic    aw_ready;
	axi_w_t  w;
	logic    w_valid;
	logic    w_ready;
	axi_b_t  b;
	logic    b_valid;
	logic    b_ready;
	axi_ar_t ar;
	logic    ar_valid;
	logic    ar_ready;
	axi_r_t  r;
	logic    r_valid;
	logic    r_ready;

	logic [15:0] lfsr = 16'd92;
	int          timeouts = 0;
	int          fails;

	axi_dual_port_sram i_dut (.*);

	initial begin
		ACLK = 1'b0;
		forever #50 ACLK = ~ACLK;
	end

	////////////////////////////////////////////////////////////
	// Random source
	////////////////////////////////////////////////////////////

	// Taps 16, 14, 13, 11
	function automatic logic [31:0] rand_bits(input int n);
		logic        fb;
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic report_stall(input string chan);
		timeouts++;
		$display("Timeout at %0t: %s channel stalled", $time, chan);
	endtask

	task automatic step();
		@(posedge ACLK);
		#DRIVE_DLY;
	endtask

	////////////////////////////////////////////////////////////
	// Channel transactions
	////////////////////////////////////////////////////////////
	task automatic write_word(input axi_addr_t addr, input axi_data_t data,
			input axi_strb_t strb, input axi_id_t id, input logic [1:0] stall);
		int n;
		aw       = '{id: id, addr: addr};
		w        = '{data: data, strb: strb};
		aw_valid = 1'b1;
		w_valid  = 1'b1;
		for (n = 0; !aw_ready && n < WAIT_LIMIT; n++)
			step();
		if (!aw_ready)
			report_stall("write address");
		step();
		aw_valid = 1'b0;
		w_valid  = 1'b0;
		for (n = 0; !b_valid && n < WAIT_LIMIT; n++)
			step();
		if (!b_valid)
			report_stall("write response");
		// Back-pressure on B
		repeat (stall)
			step();
		b_ready = 1'b1;
		step();
		b_ready = 1'b0;
	endtask

	task automatic read_word(input axi_addr_t addr, input axi_id_t id,
			input logic [1:0] stall);
		int n;
		ar       = '{id: id, addr: addr};
		ar_valid = 1'b1;
		for (n = 0; !ar_ready && n < WAIT_LIMIT; n++)
			step();
		if (!ar_ready)
			report_stall("read address");
		step();
		ar_valid = 1'b0;
		for (n = 0; !r_valid && n < WAIT_LIMIT; n++)
			step();
		if (!r_valid)
			report_stall("read data");
		repeat (stall)
			step();
		r_ready = 1'b1;
		step();
		r_ready = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] op;
		logic [31:0] idx;
		logic [31:0] ofs;
		logic [31:0] far;
		axi_data_t   data;
		axi_strb_t   strb;
		axi_id_t     id;
		logic [1:0]  wstall;
		logic [1:0]  rstall;

		ARESETn  = 1'b0;
		aw       = '0;
		aw_valid = 1'b0;
		w        = '0;
		w_valid  = 1'b0;
		b_ready  = 1'b0;
		ar       = '0;
		ar_valid = 1'b0;
		r_ready  = 1'b0;
		repeat (8)
			@(posedge ACLK);
		#DRIVE_DLY;
		ARESETn = 1'b1;
		// Quiet cycles so the idle checks see a few edges
		repeat (4)
			step();

		// Every word gets a known value first
		for (int i = 0; i < MEM_WORDS; i++) begin
			data   = rand_bits(32);
			id     = axi_id_t'(rand_bits(AXI_ID_W));
			wstall = 2'(rand_bits(2));
			write_word(axi_addr_t'(i * 4), data, 4'hf, id, wstall);
		end

		// Mixed partial writes and reads with some out of range
		for (int k = 0; k < 300; k++) begin
			op  = rand_bits(4);
			idx = rand_bits(MEM_IDX_W);
			ofs = rand_bits(BYTE_OFS_W);
			id  = axi_id_t'(rand_bits(AXI_ID_W));
			far = rand_bits(16);
			if (op < 2) begin
				idx = 32'h400 | (far << 10);
				ofs = 0;
			end
			if (op[0]) begin
				data   = rand_bits(32);
				strb   = axi_strb_t'(rand_bits(AXI_STRB_W));
				wstall = 2'(rand_bits(2));
				write_word((idx << BYTE_OFS_W) | ofs, data, strb, id, wstall);
			end else begin
				rstall = 2'(rand_bits(2));
				read_word((idx << BYTE_OFS_W) | ofs, id, rstall);
			end
		end

		// Write and read side by side on different words
		for (int k = 0; k < 40; k++) begin
			idx    = rand_bits(MEM_IDX_W);
			data   = rand_bits(32);
			strb   = axi_strb_t'(rand_bits(AXI_STRB_W));
			id     = axi_id_t'(rand_bits(AXI_ID_W));
			wstall = 2'(rand_bits(2));
			rstall = 2'(rand_bits(2));
			fork
				write_word(idx << BYTE_OFS_W, data, strb, id, wstall);
				read_word((idx ^ 32'h1) << BYTE_OFS_W, ~id, rstall);
			join
		end

		// Final sweep over the whole RAM
		for (int i = 0; i < MEM_WORDS; i++) begin
			id     = axi_id_t'(rand_bits(AXI_ID_W));
			rstall = 2'(rand_bits(2));
			read_word(axi_addr_t'(i * 4), id, rstall);
		end

		repeat (4)
			step();
		fails = i_dut.i_assert.fail_count;
		$display("Timeouts %0d, assertion failures %0d", timeouts, fails);
		if (timeouts == 0 && fails == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== all.f ====
hdl/axi_bus_pkg.sv
hdl/sram_pkg.sv
hdl/dual_port_sram.sv
hdl/axi_write_engine.sv
hdl/axi_read_engine.sv
hdl/axi_dual_port_sram.sv
test/axi_sram_assert.sv
test/tb_axi_sram.sv
